/* tb.f */
hdl/imx_ctrl_pkg.sv
hdl/reg_bus_if.sv
hdl/axi_lite_front.sv
hdl/imx_reg_bank.sv
hdl/trigger_gen.sv
hdl/imx_control_top.sv
sim/tb_imx_control.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_imx_control
FLAGS     ?= --binary --assert -j 0
BUILD_DIR ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f tb.f -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf $(BUILD_DIR)

/* sim/tb_imx_control.sv */
// Camera controller testbench
module tb_imx_control;

  localparam int         TIMEOUT = 64;
  localparam logic [1:0] OKAY    = 2'd0;
  localparam logic [1:0] SLVERR  = 2'd2;

  // One AXI access with its expected completion
  typedef struct packed {
    logic        is_write;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic [1:0]  exp_resp;
  } entry_t;

  logic        axi_clk;
  logic        axi_rst_n;
  logic        awvalid;
  logic [7:0]  awaddr;
  logic        awready;
  logic        wvalid;
  logic [31:0] wdata;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic        arvalid;
  logic [7:0]  araddr;
  logic        arready;
  logic        rvalid;
  logic        rready;
  logic [1:0]  rresp;
  logic [31:0] rdata;
  logic [2:0]  cam_trigger;
  logic [2:0]  cam_xclear_n;
  logic [2:0]  cam_master_mode;
  int          errors;
  logic [31:0] rng_state;
  logic [31:0] rand_width;
  logic [31:0] rand_period;
  entry_t      table_q[$];

  imx_control_top UUT (
    .i_axi_clk (axi_clk), .i_axi_rst_n (axi_rst_n),
    .i_awvalid (awvalid), .i_awaddr (awaddr), .o_awready (awready),
    .i_wvalid (wvalid), .i_wdata (wdata), .o_wready (wready),
    .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
    .i_arvalid (arvalid), .i_araddr (araddr), .o_arready (arready),
    .o_rvalid (rvalid), .i_rready (rready), .o_rresp (rresp), .o_rdata (rdata),
    .o_cam_trigger (cam_trigger), .o_cam_xclear_n (cam_xclear_n),
    .o_cam_master_mode (cam_master_mode)
  );

  initial begin
    axi_clk = 1'b0;
    forever #50 axi_clk = ~axi_clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic add_entry(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                           input logic [31:0] exp, input logic [1:0] resp);
    table_q.push_back({wr, addr, data, exp, resp});
  endtask

  // Master takes the response after a random delay
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    int delay;
    resp = 2'bxx;
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    do begin
      @(negedge axi_clk);
      n++;
    end while (!awready && n < TIMEOUT);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (!awready) begin
      $display("Timeout: write to address %h was never accepted", addr);
      errors++;
      return;
    end
    check("o_wready", wready, 1'b1);
    n = 0;
    while (!bvalid && n < TIMEOUT) begin
      @(negedge axi_clk);
      n++;
    end
    if (!bvalid) begin
      $display("Timeout: no write response for address %h", addr);
      errors++;
      return;
    end
    resp  = bresp;
    delay = next_random() % 4;
    repeat (delay) begin
      @(negedge axi_clk);
      check("o_bvalid", bvalid, 1'b1);
      check("o_bresp", bresp, resp);
    end
    bready = 1'b1;
    @(negedge axi_clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    int delay;
    data = 'x;
    resp = 2'bxx;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    do begin
      @(negedge axi_clk);
      n++;
    end while (!arready && n < TIMEOUT);
    arvalid = 1'b0;
    if (!arready) begin
      $display("Timeout: read of address %h was never accepted", addr);
      errors++;
      return;
    end
    n = 0;
    while (!rvalid && n < TIMEOUT) begin
      @(negedge axi_clk);
      n++;
    end
    if (!rvalid) begin
      $display("Timeout: no read data for address %h", addr);
      errors++;
      return;
    end
    data  = rdata;
    resp  = rresp;
    delay = next_random() % 4;
    repeat (delay) begin
      @(negedge axi_clk);
      check("o_rvalid", rvalid, 1'b1);
      check("o_rdata", rdata, data);
      check("o_rresp", rresp, resp);
    end
    rready = 1'b1;
    @(negedge axi_clk);
    rready = 1'b0;
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    axi_write(addr, data, resp);
    check("o_bresp", resp, OKAY);
  endtask

  task automatic run_table();
    logic [31:0] data;
    logic [1:0]  resp;
    foreach (table_q[i]) begin
      if (table_q[i].is_write) begin
        axi_write(table_q[i].addr, table_q[i].wdata, resp);
        check("o_bresp", resp, table_q[i].exp_resp);
      end else begin
        axi_read(table_q[i].addr, data, resp);
        check("o_rdata", data, table_q[i].exp_rdata);
        check("o_rresp", resp, table_q[i].exp_resp);
      end
    end
  endtask

  // Edge spacing and high time over four periods
  task automatic measure_trigger(input int period, input int high);
    int   n;
    int   cycle;
    int   last_rise;
    int   rises;
    logic prev;
    n = 0;
    while (high < period && cam_trigger[0] && n < 4 * period) begin
      @(negedge axi_clk);
      n++;
    end
    n = 0;
    while (!cam_trigger[0] && n < 4 * period) begin
      @(negedge axi_clk);
      n++;
    end
    if (!cam_trigger[0]) begin
      $display("Timeout: camera trigger never went high");
      errors++;
      return;
    end
    prev      = 1'b1;
    last_rise = 0;
    rises     = 1;
    for (cycle = 1; cycle <= 4 * period; cycle++) begin
      @(negedge axi_clk);
      check("o_cam_trigger", cam_trigger, {3{cam_trigger[0]}});
      if (high >= period) check("o_cam_trigger[0]", cam_trigger[0], 1'b1);
      if (cam_trigger[0] && !prev) begin
        check("trigger period", cycle - last_rise, period);
        last_rise = cycle;
        rises++;
      end
      if (!cam_trigger[0] && prev) check("trigger high time", cycle - last_rise, high);
      prev = cam_trigger[0];
    end
    if (high < period) check("trigger rising edges", rises, 5);
  endtask

  initial begin
    errors    = 0;
    rng_state = 32'hf1ce_d6c3;
    axi_rst_n = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    rready    = 1'b0;
    repeat (10) @(negedge axi_clk);
    axi_rst_n = 1'b1;
    @(negedge axi_clk);
    check("o_cam_xclear_n", cam_xclear_n, 3'b111);
    check("o_cam_master_mode", cam_master_mode, 3'b000);
    check("o_cam_trigger", cam_trigger, 3'b000);

    rand_width  = next_random();
    rand_period = next_random();
    // Defaults after reset
    add_entry(1'b0, 8'h00, 0, 32'h0000_0000, OKAY);
    add_entry(1'b0, 8'h0C, 0, 32'd100, OKAY);
    add_entry(1'b0, 8'h10, 0, 32'd370000, OKAY);
    add_entry(1'b0, 8'h14, 0, 32'd3, OKAY);
    add_entry(1'b0, 8'h18, 0, 32'h1000_0000, OKAY);
    // Writable registers and ignored writes to read-only words
    add_entry(1'b1, 8'h0C, rand_width, 0, OKAY);
    add_entry(1'b1, 8'h10, rand_period, 0, OKAY);
    add_entry(1'b0, 8'h0C, 0, rand_width, OKAY);
    add_entry(1'b0, 8'h10, 0, rand_period, OKAY);
    add_entry(1'b1, 8'h14, next_random(), 0, OKAY);
    add_entry(1'b1, 8'h18, next_random(), 0, OKAY);
    add_entry(1'b0, 8'h14, 0, 32'd3, OKAY);
    add_entry(1'b0, 8'h18, 0, 32'h1000_0000, OKAY);
    // Unmapped words 2, 7 and 63
    add_entry(1'b1, 8'h08, next_random(), 0, SLVERR);
    add_entry(1'b0, 8'h08, 0, 0, SLVERR);
    add_entry(1'b1, 8'h1C, next_random(), 0, SLVERR);
    add_entry(1'b0, 8'h1C, 0, 0, SLVERR);
    add_entry(1'b1, 8'hFC, next_random(), 0, SLVERR);
    add_entry(1'b0, 8'hFC, 0, 0, SLVERR);
    add_entry(1'b0, 8'h0C, 0, rand_width, OKAY);
    // Clear and master modes 101 with trigger enable off
    add_entry(1'b1, 8'h00, 32'hFFFF_DFFB, 0, OKAY);
    add_entry(1'b0, 8'h00, 0, 32'h0000_5001, OKAY);
    run_table();
    check("o_cam_xclear_n", cam_xclear_n, 3'b000);
    check("o_cam_master_mode", cam_master_mode, 3'b101);
    write_ok(8'h00, 32'h0);
    check("o_cam_xclear_n", cam_xclear_n, 3'b111);
    check("o_cam_master_mode", cam_master_mode, 3'b000);

    write_ok(8'h0C, 32'd3);
    write_ok(8'h10, 32'd10);
    write_ok(8'h00, 32'h4);
    measure_trigger(10, 3);
    write_ok(8'h0C, 32'd12);
    measure_trigger(10, 10);
    write_ok(8'h00, 32'h0);
    repeat (12) begin
      check("o_cam_trigger", cam_trigger, 3'b000);
      @(negedge axi_clk);
    end

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* hdl/imx_control_top.sv */
// Camera trigger and mode controller
module imx_control_top (
  input  logic                                    i_axi_clk,
  input  logic                                    i_axi_rst_n,
  input  logic                                    i_awvalid,
  input  logic [imx_ctrl_pkg::ADDR_WIDTH - 1:0]   i_awaddr,
  output logic                                    o_awready,
  input  logic                                    i_wvalid,
  input  imx_ctrl_pkg::reg_data_t                 i_wdata,
  output logic                                    o_wready,
  output logic                                    o_bvalid,
  input  logic                                    i_bready,
  output imx_ctrl_pkg::axi_resp_e                 o_bresp,
  input  logic                                    i_arvalid,
  input  logic [imx_ctrl_pkg::ADDR_WIDTH - 1:0]   i_araddr,
  output logic                                    o_arready,
  output logic                                    o_rvalid,
  input  logic                                    i_rready,
  output imx_ctrl_pkg::axi_resp_e                 o_rresp,
  output imx_ctrl_pkg::reg_data_t                 o_rdata,
  output logic [imx_ctrl_pkg::CAMERA_COUNT - 1:0] o_cam_trigger,
  output logic [imx_ctrl_pkg::CAMERA_COUNT - 1:0] o_cam_xclear_n,
  output logic [imx_ctrl_pkg::CAMERA_COUNT - 1:0] o_cam_master_mode
);

  logic                                    w_axi_rst;
  logic                                    w_trigger;
  logic [imx_ctrl_pkg::CAMERA_COUNT - 1:0] w_cam_clear;
  imx_ctrl_pkg::trigger_cfg_t              w_cfg;

  // Board reset is active low
  assign w_axi_rst = ~i_axi_rst_n;

  reg_bus_if u_reg_bus ();

  axi_lite_front u_front (
    .i_axi_clk (i_axi_clk),
    .i_axi_rst (w_axi_rst),
    .i_awvalid (i_awvalid),
    .i_awaddr  (i_awaddr),
    .o_awready (o_awready),
    .i_wvalid  (i_wvalid),
    .i_wdata   (i_wdata),
    .o_wready  (o_wready),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (i_arvalid),
    .i_araddr  (i_araddr),
    .o_arready (o_arready),
    .o_rvalid  (o_rvalid),
    .i_rready  (i_rready),
    .o_rresp   (o_rresp),
    .o_rdata   (o_rdata),
    .bus       (u_reg_bus.front)
  );

  imx_reg_bank u_bank (
    .i_axi_clk         (i_axi_clk),
    .i_axi_rst         (w_axi_rst),
    .bus               (u_reg_bus.bank),
    .o_cfg             (w_cfg),
    .o_cam_clear       (w_cam_clear),
    .o_cam_master_mode (o_cam_master_mode)
  );

  trigger_gen u_trigger (
    .i_axi_clk (i_axi_clk),
    .i_axi_rst (w_axi_rst),
    .i_cfg     (w_cfg),
    .o_trigger (w_trigger)
  );

  // One trigger source shared by all cameras
  assign o_cam_trigger  = {imx_ctrl_pkg::CAMERA_COUNT{w_trigger}};
  assign o_cam_xclear_n = ~w_cam_clear;

endmodule

/* hdl/trigger_gen.sv */
// Periodic camera trigger
module trigger_gen (
  input  logic                       i_axi_clk,
  input  logic                       i_axi_rst,
  input  imx_ctrl_pkg::trigger_cfg_t i_cfg,
  output logic                       o_trigger
);

  imx_ctrl_pkg::reg_data_t r_count;
  imx_ctrl_pkg::reg_data_t w_period;
  logic                    w_wrap;

  // Period of 0 or 1 means a constant level
  assign w_period = (i_cfg.period < 32'd2) ? 32'd1 : i_cfg.period;

  // Also wraps when the period shrinks below the count
  assign w_wrap = (r_count >= w_period - 32'd1);

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst || !i_cfg.enable) begin
      r_count   <= '0;
      o_trigger <= 1'b0;
    end else begin
      if (w_wrap) begin
        r_count <= '0;
      end else begin
        r_count <= r_count + 32'd1;
      end
      // Pulse covers the first pulse_width counts
      o_trigger <= (r_count < i_cfg.pulse_width);
    end
  end

  a_trigger_off: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    !i_cfg.enable |=> !o_trigger);

endmodule

/* hdl/imx_reg_bank.sv */
// Camera control register bank
module imx_reg_bank (
  input  logic                                    i_axi_clk,
  input  logic                                    i_axi_rst,
  reg_bus_if.bank                                 bus,
  output imx_ctrl_pkg::trigger_cfg_t              o_cfg,
  output logic [imx_ctrl_pkg::CAMERA_COUNT - 1:0] o_cam_clear,
  output logic [imx_ctrl_pkg::CAMERA_COUNT - 1:0] o_cam_master_mode
);

  logic                                    r_clear;
  logic                                    r_trigger_en;
  logic [imx_ctrl_pkg::CAMERA_COUNT - 1:0] r_master_mode;
  imx_ctrl_pkg::reg_data_t                 r_pulse_width;
  imx_ctrl_pkg::reg_data_t                 r_period;
  imx_ctrl_pkg::reg_data_t                 w_control_word;
  imx_ctrl_pkg::reg_data_t                 w_read_data;
  logic                                    w_mapped;
  logic                                    w_access;

  // One access per request on its first cycle
  assign w_access = bus.req && !bus.ack;

  always_comb begin
    w_control_word = '0;
    w_control_word[imx_ctrl_pkg::CTRL_BIT_CLEAR]      = r_clear;
    w_control_word[imx_ctrl_pkg::CTRL_BIT_TRIGGER_EN] = r_trigger_en;
    w_control_word[imx_ctrl_pkg::CTRL_BIT_MASTER_MODE0 +: imx_ctrl_pkg::CAMERA_COUNT] =
      r_master_mode;
  end

  // Address decode and read mux
  always_comb begin
    w_mapped    = 1'b1;
    w_read_data = '0;
    case (bus.addr)
      imx_ctrl_pkg::REG_CONTROL:      w_read_data = w_control_word;
      imx_ctrl_pkg::REG_PULSE_WIDTH:  w_read_data = r_pulse_width;
      imx_ctrl_pkg::REG_PERIOD:       w_read_data = r_period;
      imx_ctrl_pkg::REG_CAMERA_COUNT: w_read_data = imx_ctrl_pkg::CAMERA_COUNT;
      imx_ctrl_pkg::REG_VERSION:      w_read_data = imx_ctrl_pkg::VERSION_WORD;
      default:                        w_mapped    = 1'b0;
    endcase
  end

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      bus.ack       <= 1'b0;
      r_clear       <= 1'b0;
      r_trigger_en  <= 1'b0;
      r_master_mode <= '0;
      r_pulse_width <= imx_ctrl_pkg::DEFAULT_PULSE_WIDTH;
      r_period      <= imx_ctrl_pkg::DEFAULT_PERIOD;
    end else begin
      // Ack tracks req one cycle behind
      bus.ack <= bus.req;
      if (w_access && bus.write) begin
        case (bus.addr)
          imx_ctrl_pkg::REG_CONTROL: begin
            r_clear       <= bus.wdata[imx_ctrl_pkg::CTRL_BIT_CLEAR];
            r_trigger_en  <= bus.wdata[imx_ctrl_pkg::CTRL_BIT_TRIGGER_EN];
            r_master_mode <=
              bus.wdata[imx_ctrl_pkg::CTRL_BIT_MASTER_MODE0 +: imx_ctrl_pkg::CAMERA_COUNT];
          end
          imx_ctrl_pkg::REG_PULSE_WIDTH: r_pulse_width <= bus.wdata;
          imx_ctrl_pkg::REG_PERIOD:      r_period      <= bus.wdata;
          // Read-only and unmapped words keep their state
          default: ;
        endcase
      end
    end
  end

  // Completion data held until the next access
  always_ff @(posedge i_axi_clk) begin
    if (w_access) begin
      bus.rdata <= w_read_data;
      bus.err   <= !w_mapped;
    end
  end

  assign o_cfg.enable      = r_trigger_en;
  assign o_cfg.pulse_width = r_pulse_width;
  assign o_cfg.period      = r_period;

  // Same clear for every camera
  assign o_cam_clear       = {imx_ctrl_pkg::CAMERA_COUNT{r_clear}};
  assign o_cam_master_mode = r_master_mode;

  // Front end still holds req when ack comes up
  a_ack_needs_req: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    $rose(bus.ack) |-> bus.req);

endmodule

/* hdl/axi_lite_front.sv */
// AXI-Lite slave front end
module axi_lite_front (
  input  logic                                      i_axi_clk,
  input  logic                                      i_axi_rst,
  input  logic                                      i_awvalid,
  input  logic [imx_ctrl_pkg::ADDR_WIDTH - 1:0]     i_awaddr,
  output logic                                      o_awready,
  input  logic                                      i_wvalid,
  input  imx_ctrl_pkg::reg_data_t                   i_wdata,
  output logic                                      o_wready,
  output logic                                      o_bvalid,
  input  logic                                      i_bready,
  output imx_ctrl_pkg::axi_resp_e                   o_bresp,
  input  logic                                      i_arvalid,
  input  logic [imx_ctrl_pkg::ADDR_WIDTH - 1:0]     i_araddr,
  output logic                                      o_arready,
  output logic                                      o_rvalid,
  input  logic                                      i_rready,
  output imx_ctrl_pkg::axi_resp_e                   o_rresp,
  output imx_ctrl_pkg::reg_data_t                   o_rdata,
  reg_bus_if.front                                  bus
);

  imx_ctrl_pkg::bus_state_e r_state;
  logic                     w_wr_accept;
  logic                     w_rd_accept;

  // Write wins when both channels are waiting
  assign w_wr_accept = (r_state == imx_ctrl_pkg::IDLE) && i_awvalid && i_wvalid;
  assign w_rd_accept = (r_state == imx_ctrl_pkg::IDLE) && !w_wr_accept && i_arvalid;

  always_ff @(posedge i_axi_clk) begin
    if (i_axi_rst) begin
      r_state   <= imx_ctrl_pkg::IDLE;
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_arready <= 1'b0;
      o_bvalid  <= 1'b0;
      o_rvalid  <= 1'b0;
      o_bresp   <= imx_ctrl_pkg::RESP_OKAY;
      o_rresp   <= imx_ctrl_pkg::RESP_OKAY;
      bus.req   <= 1'b0;
      bus.write <= 1'b0;
    end else begin
      // Ready strobes last a single cycle
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_arready <= 1'b0;
      case (r_state)
        imx_ctrl_pkg::IDLE: begin
          if (w_wr_accept) begin
            o_awready <= 1'b1;
            o_wready  <= 1'b1;
            bus.req   <= 1'b1;
            bus.write <= 1'b1;
            r_state   <= imx_ctrl_pkg::WR_REQ;
          end else if (w_rd_accept) begin
            o_arready <= 1'b1;
            bus.req   <= 1'b1;
            bus.write <= 1'b0;
            r_state   <= imx_ctrl_pkg::RD_REQ;
          end
        end
        imx_ctrl_pkg::WR_REQ: begin
          if (bus.ack) begin
            bus.req  <= 1'b0;
            o_bresp  <= bus.err ? imx_ctrl_pkg::RESP_SLVERR : imx_ctrl_pkg::RESP_OKAY;
            o_bvalid <= 1'b1;
            r_state  <= imx_ctrl_pkg::WR_RESP;
          end
        end
        imx_ctrl_pkg::RD_REQ: begin
          if (bus.ack) begin
            bus.req  <= 1'b0;
            o_rresp  <= bus.err ? imx_ctrl_pkg::RESP_SLVERR : imx_ctrl_pkg::RESP_OKAY;
            o_rvalid <= 1'b1;
            r_state  <= imx_ctrl_pkg::RD_RESP;
          end
        end
        imx_ctrl_pkg::WR_RESP: begin
          if (i_bready) begin
            o_bvalid <= 1'b0;
            r_state  <= imx_ctrl_pkg::REQ_DROP;
          end
        end
        imx_ctrl_pkg::RD_RESP: begin
          if (i_rready) begin
            o_rvalid <= 1'b0;
            r_state  <= imx_ctrl_pkg::REQ_DROP;
          end
        end
        imx_ctrl_pkg::REQ_DROP: begin
          // Bank must release ack before the next request
          if (!bus.ack) begin
            r_state <= imx_ctrl_pkg::IDLE;
          end
        end
        default: r_state <= imx_ctrl_pkg::IDLE;
      endcase
    end
  end

  // Address and data capture
  always_ff @(posedge i_axi_clk) begin
    if (w_wr_accept) begin
      bus.addr  <= i_awaddr[imx_ctrl_pkg::ADDR_WIDTH - 1:2];
      bus.wdata <= i_wdata;
    end else if (w_rd_accept) begin
      bus.addr  <= i_araddr[imx_ctrl_pkg::ADDR_WIDTH - 1:2];
    end
    if (r_state == imx_ctrl_pkg::RD_REQ && bus.ack) begin
      o_rdata <= bus.rdata;
    end
  end

  // Bank follows the four-phase release
  a_ack_release: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    (!bus.req && !$past(bus.req)) |-> !bus.ack);

  a_bvalid_hold: assert property (@(posedge i_axi_clk) disable iff (i_axi_rst)
    (o_bvalid && !i_bready) |=> o_bvalid);

endmodule

/* hdl/reg_bus_if.sv */
// Register access bus
interface reg_bus_if;

  // Request side
  logic                  req;
  logic                  write;
  imx_ctrl_pkg::reg_addr_t addr;
  imx_ctrl_pkg::reg_data_t wdata;

  // Completion side, valid while ack is high
  imx_ctrl_pkg::reg_data_t rdata;
  logic                  err;
  logic                  ack;

  modport front (
    output req,
    output write,
    output addr,
    output wdata,
    input  rdata,
    input  err,
    input  ack
  );

  modport bank (
    input  req,
    input  write,
    input  addr,
    input  wdata,
    output rdata,
    output err,
    output ack
  );

endinterface

/* hdl/imx_ctrl_pkg.sv */
// Camera control shared definitions
package imx_ctrl_pkg;

  // Bus geometry
  localparam int ADDR_WIDTH   = 8;
  localparam int DATA_WIDTH   = 32;
  localparam int CAMERA_COUNT = 3;

  // Word address drops the two byte-lane bits
  typedef logic [ADDR_WIDTH - 3:0] reg_addr_t;
  typedef logic [DATA_WIDTH - 1:0] reg_data_t;

  // Register map, word addresses
  localparam reg_addr_t REG_CONTROL      = 6'd0;
  localparam reg_addr_t REG_PULSE_WIDTH  = 6'd3;
  localparam reg_addr_t REG_PERIOD       = 6'd4;
  localparam reg_addr_t REG_CAMERA_COUNT = 6'd5;
  localparam reg_addr_t REG_VERSION      = 6'd6;

  // Control register bits
  localparam int CTRL_BIT_CLEAR        = 0;
  localparam int CTRL_BIT_TRIGGER_EN   = 2;
  localparam int CTRL_BIT_MASTER_MODE0 = 12;

  // Reset values, period gives about 200 Hz at 74 MHz
  localparam reg_data_t DEFAULT_PULSE_WIDTH = 32'd100;
  localparam reg_data_t DEFAULT_PERIOD      = 32'd370000;

  // Major 1, minor 0, revision 0
  localparam reg_data_t VERSION_WORD = {4'd1, 8'd0, 4'd0, 16'd0};

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axi_resp_e;

  typedef enum logic [2:0] {
    IDLE,
    WR_REQ,
    RD_REQ,
    WR_RESP,
    RD_RESP,
    REQ_DROP
  } bus_state_e;

  typedef struct packed {
    logic      enable;
    reg_data_t pulse_width;
    reg_data_t period;
  } trigger_cfg_t;

endpackage
